//--- verilog/host_consts.svh
`ifndef HOST_CONSTS_SVH
`define HOST_CONSTS_SVH

// ------------------------------------------------------------
// stream and queue widths
// ------------------------------------------------------------
`define HOST_DATA_WID      64
`define HOST_QID_WID       12
// num_q is one bit wider so a full 4096-queue range fits
`define HOST_NUMQ_WID      13
`define HOST_NUM_FUNC      4
`define HOST_DROP_CNT_WID  16

// ------------------------------------------------------------
// register access
// ------------------------------------------------------------
`define APB_ADDR_WID       8
`define APB_DATA_WID       32

// queue range j lives at REG_Q_CFG_BASE + 4*j
`define REG_Q_CFG_BASE     8'h00
`define REG_Q_NUM_LSB      16
`define REG_DROP_CNT       8'h10

`endif

//--- verilog/host_pkg.sv
package host_pkg;

    // ------------------------------------------------------------
    // function types
    // ------------------------------------------------------------

    // listed in priority order, lowest value wins on overlap
    typedef enum logic [1:0] {
        FUNC_PF  = 2'd0,
        FUNC_VF0 = 2'd1,
        FUNC_VF1 = 2'd2,
        FUNC_VF2 = 2'd3
    } func_typ_e;

    // ------------------------------------------------------------
    // register bus phases
    // ------------------------------------------------------------

    // state names the phase that has just been seen on the bus
    // APB_SETUP means the next cycle is expected to be the access
    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_SETUP  = 2'd1,
        APB_ACCESS = 2'd2
    } apb_state_e;

endpackage

//--- verilog/host_q_cfg_regs.sv
`timescale 1ns/1ps
`include "host_consts.svh"

module host_q_cfg_regs
    import host_pkg::*;
(
    input  logic                          core_clk,
    input  logic                          srst,

    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`APB_ADDR_WID-1:0]      paddr,
    input  logic [`APB_DATA_WID-1:0]      pwdata,
    output logic [`APB_DATA_WID-1:0]      prdata,
    output logic                          pready,
    output logic                          pslverr,

    input  logic                          drop_pulse,

    output logic [`HOST_QID_WID-1:0]      q_base_0,
    output logic [`HOST_QID_WID-1:0]      q_base_1,
    output logic [`HOST_QID_WID-1:0]      q_base_2,
    output logic [`HOST_QID_WID-1:0]      q_base_3,
    output logic [`HOST_NUMQ_WID-1:0]     q_num_0,
    output logic [`HOST_NUMQ_WID-1:0]     q_num_1,
    output logic [`HOST_NUMQ_WID-1:0]     q_num_2,
    output logic [`HOST_NUMQ_WID-1:0]     q_num_3
);

    apb_state_e                     apb_state;
    logic                           access_ph;
    logic                           wr_en;

    logic [`APB_ADDR_WID-1:0]       cfg_off;
    logic [1:0]                     cfg_idx;
    logic                           cfg_hit;
    logic                           drop_hit;
    logic [`APB_DATA_WID-1:0]       rd_data;

    logic [`HOST_QID_WID-1:0]       q_base [`HOST_NUM_FUNC];
    logic [`HOST_NUMQ_WID-1:0]      q_num  [`HOST_NUM_FUNC];
    logic [`HOST_DROP_CNT_WID-1:0]  drop_cnt;

    // ------------------------------------------------------------
    // bus phase tracking
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (srst) begin
            apb_state <= APB_IDLE;
        end else begin
            case (apb_state)
                APB_IDLE:   apb_state <= psel ? APB_SETUP : APB_IDLE;
                APB_SETUP: begin
                    if (!psel)
                        apb_state <= APB_IDLE;
                    else if (penable)
                        apb_state <= APB_ACCESS;
                end
                APB_ACCESS: apb_state <= (psel && !penable) ? APB_SETUP : APB_IDLE;
                default:    apb_state <= APB_IDLE;
            endcase
        end
    end

    // zero wait states, access always completes
    assign access_ph = psel && penable;
    assign pready    = access_ph;
    assign wr_en     = access_ph && pwrite && (apb_state == APB_SETUP);

    // ------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------
    assign cfg_off  = paddr - `REG_Q_CFG_BASE;
    assign cfg_idx  = cfg_off[3:2];
    assign cfg_hit  = (cfg_off[1:0] == 2'b00) && (cfg_off[`APB_ADDR_WID-1:4] == '0);
    assign drop_hit = (paddr == `REG_DROP_CNT);

    always_comb begin
        rd_data = '0;
        if (cfg_hit) begin
            rd_data[`HOST_QID_WID-1:0]                = q_base[cfg_idx];
            rd_data[`REG_Q_NUM_LSB +: `HOST_NUMQ_WID] = q_num[cfg_idx];
        end else if (drop_hit) begin
            rd_data[`HOST_DROP_CNT_WID-1:0] = drop_cnt;
        end
    end

    assign prdata  = access_ph ? rd_data : '0;
    assign pslverr = access_ph && !(cfg_hit || drop_hit);

    // ------------------------------------------------------------
    // queue range registers
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (srst) begin
            for (int j = 0; j < `HOST_NUM_FUNC; j++) begin
                q_base[j] <= '0;
                q_num[j]  <= '0;
            end
        end else if (wr_en && cfg_hit) begin
            q_base[cfg_idx] <= pwdata[`HOST_QID_WID-1:0];
            q_num[cfg_idx]  <= pwdata[`REG_Q_NUM_LSB +: `HOST_NUMQ_WID];
        end
    end

    assign q_base_0 = q_base[0];
    assign q_base_1 = q_base[1];
    assign q_base_2 = q_base[2];
    assign q_base_3 = q_base[3];
    assign q_num_0  = q_num[0];
    assign q_num_1  = q_num[1];
    assign q_num_2  = q_num[2];
    assign q_num_3  = q_num[3];

    // ------------------------------------------------------------
    // drop counter
    // ------------------------------------------------------------

    // any write clears, a drop in the same cycle still counts
    always_ff @(posedge core_clk) begin
        if (srst) begin
            drop_cnt <= '0;
        end else if (wr_en && drop_hit) begin
            drop_cnt <= drop_pulse ? `HOST_DROP_CNT_WID'(1) : '0;
        end else if (drop_pulse && !(&drop_cnt)) begin
            drop_cnt <= drop_cnt + 1'b1;
        end
    end

endmodule

//--- verilog/host_q_classify.sv
`timescale 1ns/1ps
`include "host_consts.svh"

module host_q_classify
    import host_pkg::*;
(
    input  logic                          core_clk,
    input  logic                          srst,

    input  logic                          host_valid,
    output logic                          host_ready,
    input  logic [`HOST_DATA_WID-1:0]     host_data,
    input  logic                          host_last,
    input  logic [`HOST_QID_WID-1:0]      host_qid,

    input  logic [`HOST_QID_WID-1:0]      q_base_0,
    input  logic [`HOST_QID_WID-1:0]      q_base_1,
    input  logic [`HOST_QID_WID-1:0]      q_base_2,
    input  logic [`HOST_QID_WID-1:0]      q_base_3,
    input  logic [`HOST_NUMQ_WID-1:0]     q_num_0,
    input  logic [`HOST_NUMQ_WID-1:0]     q_num_1,
    input  logic [`HOST_NUMQ_WID-1:0]     q_num_2,
    input  logic [`HOST_NUMQ_WID-1:0]     q_num_3,

    output logic                          tag_valid,
    input  logic                          tag_ready,
    output logic [`HOST_DATA_WID-1:0]     tag_data,
    output logic                          tag_last,
    output func_typ_e                     tag_typ,

    output logic                          drop_pulse
);

    logic [`HOST_QID_WID-1:0]   q_base    [`HOST_NUM_FUNC];
    logic [`HOST_NUMQ_WID-1:0]  q_num     [`HOST_NUM_FUNC];
    logic [`HOST_NUMQ_WID-1:0]  range_end [`HOST_NUM_FUNC];
    logic [`HOST_NUM_FUNC-1:0]  hit;
    logic                       hit_any;
    func_typ_e                  hit_typ;

    logic                       ready_en;
    logic                       sop;
    logic                       accept;
    logic                       keep_q;
    func_typ_e                  typ_q;
    logic                       keep_now;
    func_typ_e                  typ_now;

    assign q_base[0] = q_base_0;
    assign q_base[1] = q_base_1;
    assign q_base[2] = q_base_2;
    assign q_base[3] = q_base_3;
    assign q_num[0]  = q_num_0;
    assign q_num[1]  = q_num_1;
    assign q_num[2]  = q_num_2;
    assign q_num[3]  = q_num_3;

    // ------------------------------------------------------------
    // range match, first function wins
    // ------------------------------------------------------------
    always_comb begin
        for (int j = 0; j < `HOST_NUM_FUNC; j++) begin
            range_end[j] = {1'b0, q_base[j]} + q_num[j];
            hit[j] = (host_qid >= q_base[j]) && ({1'b0, host_qid} < range_end[j]);
        end
    end

    always_comb begin
        hit_any = 1'b0;
        hit_typ = FUNC_PF;
        for (int j = `HOST_NUM_FUNC - 1; j >= 0; j--) begin
            if (hit[j]) begin
                hit_any = 1'b1;
                hit_typ = func_typ_e'(j[1:0]);
            end
        end
    end

    // ------------------------------------------------------------
    // per-packet decision
    // ------------------------------------------------------------

    // held low through reset, up one cycle later
    always_ff @(posedge core_clk) begin
        ready_en <= !srst;
    end

    assign host_ready = ready_en && (!tag_valid || tag_ready);
    assign accept     = host_valid && host_ready;

    always_ff @(posedge core_clk) begin
        if (srst) begin
            sop    <= 1'b1;
            keep_q <= 1'b0;
            typ_q  <= FUNC_PF;
        end else if (accept) begin
            sop <= host_last;
            if (sop) begin
                keep_q <= hit_any;
                typ_q  <= hit_typ;
            end
        end
    end

    // qid only looked at on the first beat
    assign keep_now = sop ? hit_any : keep_q;
    assign typ_now  = sop ? hit_typ : typ_q;

    assign drop_pulse = accept && !keep_now && host_last;

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (srst)
            tag_valid <= 1'b0;
        else if (accept && keep_now)
            tag_valid <= 1'b1;
        else if (tag_ready)
            tag_valid <= 1'b0;
    end

    always_ff @(posedge core_clk) begin
        if (accept && keep_now) begin
            tag_data <= host_data;
            tag_last <= host_last;
            tag_typ  <= typ_now;
        end
    end

endmodule

//--- verilog/host_func_demux.sv
`timescale 1ns/1ps
`include "host_consts.svh"

module host_func_demux
    import host_pkg::*;
(
    input  logic                          core_clk,
    input  logic                          srst,

    input  logic                          tag_valid,
    output logic                          tag_ready,
    input  logic [`HOST_DATA_WID-1:0]     tag_data,
    input  logic                          tag_last,
    input  func_typ_e                     tag_typ,

    output logic                          main_valid,
    input  logic                          main_ready,
    output logic [`HOST_DATA_WID-1:0]     main_data,
    output logic                          main_last,
    output func_typ_e                     main_typ,

    output logic                          side_valid,
    input  logic                          side_ready,
    output logic [`HOST_DATA_WID-1:0]     side_data,
    output logic                          side_last
);

    logic                       sop;
    logic                       tag_acc;
    logic                       route_q;
    logic                       route_now;

    logic                       out_valid;
    logic                       out_side;
    logic                       out_ready;
    logic [`HOST_DATA_WID-1:0]  out_data;
    logic                       out_last;
    func_typ_e                  out_typ;

    // ------------------------------------------------------------
    // route selection
    // ------------------------------------------------------------
    assign tag_acc = tag_valid && tag_ready;

    always_ff @(posedge core_clk) begin
        if (srst) begin
            sop     <= 1'b1;
            route_q <= 1'b0;
        end else if (tag_acc) begin
            sop <= tag_last;
            if (sop)
                route_q <= (tag_typ == FUNC_VF2);
        end
    end

    // high selects the side path
    assign route_now = sop ? (tag_typ == FUNC_VF2) : route_q;

    // ------------------------------------------------------------
    // output stage
    // ------------------------------------------------------------

    // only the path holding the beat can stall us
    assign out_ready = out_side ? side_ready : main_ready;
    assign tag_ready = !out_valid || out_ready;

    always_ff @(posedge core_clk) begin
        if (srst) begin
            out_valid <= 1'b0;
            out_side  <= 1'b0;
        end else if (tag_acc) begin
            out_valid <= 1'b1;
            out_side  <= route_now;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (tag_acc) begin
            out_data <= tag_data;
            out_last <= tag_last;
            out_typ  <= tag_typ;
        end
    end

    assign main_valid = out_valid && !out_side;
    assign main_data  = out_data;
    assign main_last  = out_last;
    assign main_typ   = out_typ;

    assign side_valid = out_valid && out_side;
    assign side_data  = out_data;
    assign side_last  = out_last;

endmodule

//--- verilog/host_ingress_top.sv
`timescale 1ns/1ps
`include "host_consts.svh"

module host_ingress_top
    import host_pkg::*;
(
    input  logic                          core_clk,
    input  logic                          srst,

    // register bus
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`APB_ADDR_WID-1:0]      paddr,
    input  logic [`APB_DATA_WID-1:0]      pwdata,
    output logic [`APB_DATA_WID-1:0]      prdata,
    output logic                          pready,
    output logic                          pslverr,

    // from host DMA
    input  logic                          host_valid,
    output logic                          host_ready,
    input  logic [`HOST_DATA_WID-1:0]     host_data,
    input  logic                          host_last,
    input  logic [`HOST_QID_WID-1:0]      host_qid,

    // PF, VF0, VF1 traffic
    output logic                          main_valid,
    input  logic                          main_ready,
    output logic [`HOST_DATA_WID-1:0]     main_data,
    output logic                          main_last,
    output func_typ_e                     main_typ,

    // VF2 traffic
    output logic                          side_valid,
    input  logic                          side_ready,
    output logic [`HOST_DATA_WID-1:0]     side_data,
    output logic                          side_last
);

    logic [`HOST_QID_WID-1:0]   q_base_0;
    logic [`HOST_QID_WID-1:0]   q_base_1;
    logic [`HOST_QID_WID-1:0]   q_base_2;
    logic [`HOST_QID_WID-1:0]   q_base_3;
    logic [`HOST_NUMQ_WID-1:0]  q_num_0;
    logic [`HOST_NUMQ_WID-1:0]  q_num_1;
    logic [`HOST_NUMQ_WID-1:0]  q_num_2;
    logic [`HOST_NUMQ_WID-1:0]  q_num_3;
    logic                       drop_pulse;

    logic                       tag_valid;
    logic                       tag_ready;
    logic [`HOST_DATA_WID-1:0]  tag_data;
    logic                       tag_last;
    func_typ_e                  tag_typ;

    host_q_cfg_regs host_q_cfg_regs_i (
        .core_clk, .srst,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .drop_pulse,
        .q_base_0, .q_base_1, .q_base_2, .q_base_3,
        .q_num_0, .q_num_1, .q_num_2, .q_num_3
    );

    host_q_classify host_q_classify_i (
        .core_clk, .srst,
        .host_valid, .host_ready, .host_data, .host_last, .host_qid,
        .q_base_0, .q_base_1, .q_base_2, .q_base_3,
        .q_num_0, .q_num_1, .q_num_2, .q_num_3,
        .tag_valid, .tag_ready, .tag_data, .tag_last, .tag_typ,
        .drop_pulse
    );

    host_func_demux host_func_demux_i (
        .core_clk, .srst,
        .tag_valid, .tag_ready, .tag_data, .tag_last, .tag_typ,
        .main_valid, .main_ready, .main_data, .main_last, .main_typ,
        .side_valid, .side_ready, .side_data, .side_last
    );

endmodule

//--- dv/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 3
) (
    output logic core_clk,
    output logic srst
);

    initial begin
        core_clk = 1'b0;
        forever #(PERIOD_NS / 2) core_clk = ~core_clk;
    end

    // released on a falling edge, like every other driven input
    initial begin
        srst = 1'b1;
        repeat (RST_CYCLES) @(posedge core_clk);
        @(negedge core_clk);
        srst = 1'b0;
    end

endmodule

//--- dv/host_ingress_tb.sv
`timescale 1ns/1ps
`include "host_consts.svh"

module host_ingress_tb
    import host_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic                        core_clk;
    logic                        srst;

    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`APB_ADDR_WID-1:0]    paddr;
    logic [`APB_DATA_WID-1:0]    pwdata;
    logic [`APB_DATA_WID-1:0]    prdata;
    logic                        pready;
    logic                        pslverr;

    logic                        host_valid;
    logic                        host_ready;
    logic [`HOST_DATA_WID-1:0]   host_data;
    logic                        host_last;
    logic [`HOST_QID_WID-1:0]    host_qid;

    logic                        main_valid;
    logic                        main_ready = 1'b1;
    logic [`HOST_DATA_WID-1:0]   main_data;
    logic                        main_last;
    func_typ_e                   main_typ;

    logic                        side_valid;
    logic                        side_ready = 1'b1;
    logic [`HOST_DATA_WID-1:0]   side_data;
    logic                        side_last;

    integer                      seed = 32'h3d50;
    integer                      rdy_seed = 32'h3d50;
    int                          err_cnt = 0;
    int                          exp_drops = 0;
    bit                          bp_en = 1'b0;

    // reference copy of the programmed ranges
    int                          cfg_base [`HOST_NUM_FUNC];
    int                          cfg_num  [`HOST_NUM_FUNC];

    logic [`HOST_DATA_WID-1:0]   pkt_buf [16];
    // {typ, last, data} and {last, data}
    logic [66:0]                 main_q [$];
    logic [64:0]                 side_q [$];
    logic [66:0]                 main_exp;
    logic [64:0]                 side_exp;

    logic [`HOST_QID_WID-1:0]    bp_qids [8] = '{12'h010, 12'h018, 12'h100, 12'h12f,
                                                 12'h201, 12'h300, 12'h33f, 12'h500};

    clk_rst_gen clk_rst_gen_i (.core_clk, .srst);

    host_ingress_top host_ingress_top_i (
        .core_clk, .srst,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .host_valid, .host_ready, .host_data, .host_last, .host_qid,
        .main_valid, .main_ready, .main_data, .main_last, .main_typ,
        .side_valid, .side_ready, .side_data, .side_last
    );

    // ------------------------------------------------------------
    // checking helpers
    // ------------------------------------------------------------
    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        err_cnt++;
    endtask

    // first function whose range holds qid, -1 when none does
    // range end wraps at 13 bits
    function automatic int match_func(input logic [`HOST_QID_WID-1:0] qid);
        for (int j = 0; j < `HOST_NUM_FUNC; j++) begin
            if (int'(qid) >= cfg_base[j] && int'(qid) < ((cfg_base[j] + cfg_num[j]) % 8192))
                return j;
        end
        return -1;
    endfunction

    // ------------------------------------------------------------
    // output monitor and ready drive
    // ------------------------------------------------------------
    always @(posedge core_clk) begin
        if (!srst && main_valid && main_ready) begin
            if (main_q.size() == 0) begin
                $display("unexpected beat on the main path at %0t", $time);
                err_cnt++;
            end else begin
                main_exp = main_q.pop_front();
                check_val("main_data", main_exp[63:0], main_data);
                check_val("main_last", 64'(main_exp[64]), 64'(main_last));
                check_val("main_typ", 64'(main_exp[66:65]), 64'(main_typ));
            end
        end
        if (!srst && side_valid && side_ready) begin
            if (side_q.size() == 0) begin
                $display("unexpected beat on the side path at %0t", $time);
                err_cnt++;
            end else begin
                side_exp = side_q.pop_front();
                check_val("side_data", side_exp[63:0], side_data);
                check_val("side_last", 64'(side_exp[64]), 64'(side_last));
            end
        end
    end

    // roughly three of four cycles ready under back-pressure
    always @(negedge core_clk) begin
        if (bp_en) begin
            main_ready = ($random(rdy_seed) % 4) != 0;
            side_ready = ($random(rdy_seed) % 4) != 0;
        end else begin
            main_ready = 1'b1;
            side_ready = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // register bus
    // ------------------------------------------------------------
    task automatic apb_transfer(input bit wr, input logic [`APB_ADDR_WID-1:0] addr,
                                input logic [`APB_DATA_WID-1:0] wdata,
                                output logic [`APB_DATA_WID-1:0] rdata, output logic err);
        int n;
        @(negedge core_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge core_clk);
        penable = 1'b1;
        n = 0;
        @(posedge core_clk);
        while (!pready && n < WAIT_LIMIT) begin
            n++;
            @(posedge core_clk);
        end
        if (!pready)
            report_timeout("pready on the register bus");
        rdata = prdata;
        err   = pslverr;
        @(negedge core_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [`APB_ADDR_WID-1:0] addr,
                             input logic [`APB_DATA_WID-1:0] wdata, input logic exp_err);
        logic [`APB_DATA_WID-1:0] rd;
        logic                     err;
        apb_transfer(1'b1, addr, wdata, rd, err);
        check_val("pslverr", 64'(exp_err), 64'(err));
    endtask

    task automatic apb_read(input logic [`APB_ADDR_WID-1:0] addr,
                            output logic [`APB_DATA_WID-1:0] rdata, input logic exp_err);
        logic err;
        apb_transfer(1'b0, addr, '0, rdata, err);
        check_val("pslverr", 64'(exp_err), 64'(err));
        if (exp_err)
            check_val("prdata", 64'd0, 64'(rdata));
    endtask

    task automatic set_range(input int j, input logic [11:0] base, input logic [12:0] num);
        apb_write(`REG_Q_CFG_BASE + 8'(4 * j), {3'b000, num, 4'h0, base}, 1'b0);
        cfg_base[j] = int'(base);
        cfg_num[j]  = int'(num);
    endtask

    task automatic check_range(input int j);
        logic [`APB_DATA_WID-1:0] rd;
        logic [`APB_DATA_WID-1:0] exp;
        apb_read(`REG_Q_CFG_BASE + 8'(4 * j), rd, 1'b0);
        exp = {3'b000, 13'(cfg_num[j]), 4'h0, 12'(cfg_base[j])};
        check_val($sformatf("q_cfg_%0d", j), 64'(exp), 64'(rd));
    endtask

    task automatic check_drops();
        logic [`APB_DATA_WID-1:0] rd;
        apb_read(`REG_DROP_CNT, rd, 1'b0);
        check_val("drop_cnt", 64'(exp_drops), 64'(rd));
    endtask

    // any written value clears the count
    task automatic clear_drops();
        apb_write(`REG_DROP_CNT, 32'h0000_5a5a, 1'b0);
        exp_drops = 0;
    endtask

    // ------------------------------------------------------------
    // host stream
    // ------------------------------------------------------------
    task automatic build_packet(input int len);
        for (int i = 0; i < len; i++)
            pkt_buf[i] = {$random(seed), $random(seed)};
    endtask

    task automatic expect_packet(input logic [`HOST_QID_WID-1:0] qid, input int len);
        int         f;
        logic [1:0] typ;
        f = match_func(qid);
        typ = 2'(f);
        if (f < 0) begin
            exp_drops++;
        end else begin
            for (int i = 0; i < len; i++) begin
                if (f == int'(FUNC_VF2))
                    side_q.push_back({(i == len - 1), pkt_buf[i]});
                else
                    main_q.push_back({typ, (i == len - 1), pkt_buf[i]});
            end
        end
    endtask

    task automatic send_packet(input logic [`HOST_QID_WID-1:0] qid, input int len);
        int gap;
        int n;
        for (int i = 0; i < len; i++) begin
            if (bp_en) begin
                gap = $unsigned($random(seed)) % 3;
                repeat (gap) begin
                    @(negedge core_clk);
                    host_valid = 1'b0;
                end
            end
            @(negedge core_clk);
            host_valid = 1'b1;
            host_data  = pkt_buf[i];
            host_last  = (i == len - 1);
            host_qid   = qid;
            n = 0;
            @(posedge core_clk);
            while (!host_ready && n < WAIT_LIMIT) begin
                n++;
                @(posedge core_clk);
            end
            if (!host_ready)
                report_timeout("host_ready to accept a beat");
        end
        @(negedge core_clk);
        host_valid = 1'b0;
        host_last  = 1'b0;
    endtask

    task automatic run_packet(input logic [`HOST_QID_WID-1:0] qid, input int len);
        build_packet(len);
        expect_packet(qid, len);
        send_packet(qid, len);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((main_q.size() != 0 || side_q.size() != 0) && n < 4 * WAIT_LIMIT) begin
            @(posedge core_clk);
            n++;
        end
        repeat (4) @(posedge core_clk);
        if (main_q.size() != 0 || side_q.size() != 0)
            report_timeout($sformatf("%0d main and %0d side beats still owed",
                                     main_q.size(), side_q.size()));
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_reset_state();
        logic [`APB_DATA_WID-1:0] rd;
        int                       n;
        @(posedge core_clk);
        @(negedge core_clk);
        check_val("host_ready", 64'd0, 64'(host_ready));
        n = 0;
        while (srst && n < WAIT_LIMIT) begin
            @(negedge core_clk);
            n++;
        end
        if (srst)
            report_timeout("reset release");
        check_val("main_valid", 64'd0, 64'(main_valid));
        check_val("side_valid", 64'd0, 64'(side_valid));
        check_val("pready", 64'd0, 64'(pready));
        check_val("pslverr", 64'd0, 64'(pslverr));
        check_val("prdata", 64'd0, 64'(prdata));
        n = 0;
        while (!host_ready && n < WAIT_LIMIT) begin
            @(negedge core_clk);
            n++;
        end
        if (!host_ready)
            report_timeout("host_ready after reset");
        for (int j = 0; j < `HOST_NUM_FUNC; j++)
            check_range(j);
        apb_read(`REG_DROP_CNT, rd, 1'b0);
        check_val("drop_cnt", 64'd0, 64'(rd));
    endtask

    // num_q is zero everywhere after reset
    task automatic test_default_drop();
        run_packet(12'h000, 2);
        run_packet(12'h123, 1);
        run_packet(12'hfff, 3);
        wait_drain();
        check_drops();
        clear_drops();
        check_drops();
    endtask

    task automatic test_reg_access();
        logic [`APB_DATA_WID-1:0] rd;
        set_range(0, 12'h5a5, 13'h0a5a);
        set_range(1, 12'hfff, 13'h1fff);
        set_range(2, 12'h000, 13'h1000);
        set_range(3, 12'h800, 13'h0001);
        for (int j = 0; j < `HOST_NUM_FUNC; j++)
            check_range(j);
        apb_read(8'h14, rd, 1'b1);
        apb_read(8'h02, rd, 1'b1);
        apb_read(8'h80, rd, 1'b1);
        apb_write(8'h20, 32'hffff_ffff, 1'b1);
        for (int j = 0; j < `HOST_NUM_FUNC; j++)
            check_range(j);
    endtask

    task automatic set_disjoint();
        set_range(0, 12'h010, 13'd16);
        set_range(1, 12'h100, 13'd32);
        set_range(2, 12'h200, 13'd8);
        set_range(3, 12'h300, 13'd64);
    endtask

    task automatic test_routing();
        set_disjoint();
        run_packet(12'h010, 3);
        run_packet(12'h01f, 1);
        run_packet(12'h100, 4);
        run_packet(12'h300, 3);
        run_packet(12'h11f, 2);
        run_packet(12'h200, 5);
        run_packet(12'h33f, 2);
        run_packet(12'h207, 1);
        wait_drain();
    endtask

    // overlapping ranges, VF2 covers the whole id space
    task automatic test_priority();
        set_range(0, 12'h040, 13'h010);
        set_range(1, 12'h048, 13'h010);
        set_range(2, 12'h050, 13'h020);
        set_range(3, 12'h000, 13'h1000);
        run_packet(12'h040, 2);
        run_packet(12'h04f, 1);
        run_packet(12'h050, 2);
        run_packet(12'h058, 3);
        run_packet(12'h06f, 1);
        run_packet(12'h070, 2);
        run_packet(12'hfff, 1);
        run_packet(12'h000, 1);
        wait_drain();
    endtask

    task automatic test_drop_count();
        set_disjoint();
        clear_drops();
        run_packet(12'h005, 2);
        run_packet(12'h020, 1);
        run_packet(12'h010, 2);
        run_packet(12'h150, 3);
        run_packet(12'h340, 1);
        run_packet(12'h800, 4);
        wait_drain();
        check_drops();
        clear_drops();
        check_drops();
    endtask

    task automatic test_backpressure();
        int idx;
        int len;
        set_disjoint();
        clear_drops();
        bp_en = 1'b1;
        for (int k = 0; k < 40; k++) begin
            idx = $unsigned($random(seed)) % 8;
            len = 1 + $unsigned($random(seed)) % 6;
            run_packet(bp_qids[idx], len);
        end
        wait_drain();
        bp_en = 1'b0;
        check_drops();
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        host_valid = 1'b0;
        host_data  = '0;
        host_last  = 1'b0;
        host_qid   = '0;
        for (int j = 0; j < `HOST_NUM_FUNC; j++) begin
            cfg_base[j] = 0;
            cfg_num[j]  = 0;
        end

        test_reset_state();
        test_default_drop();
        test_reg_access();
        test_routing();
        test_priority();
        test_drop_count();
        test_backpressure();

        $display("error count: %0d", err_cnt);
        if (err_cnt == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/host_pkg.sv
verilog/host_q_cfg_regs.sv
verilog/host_q_classify.sv
verilog/host_func_demux.sv
verilog/host_ingress_top.sv
dv/clk_rst_gen.sv
dv/host_ingress_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the host ingress testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module host_ingress_tb -f sim.f \
    -o host_ingress_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/host_ingress_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation did not complete"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
